// File: design/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Number of mhpmcounter/mhpmevent pairs from 1 to 29
`define HPM_COUNT 4

// MXL = 1 with the I and M extensions
`define MISA_VALUE 32'h4000_1100

// Direct mode
`define MTVEC_RESET 32'h0000_0100

`endif

// File: design/csr_pkg.sv
package csr_pkg;

  typedef enum logic [11:0] {
    csr_mstatus       = 12'h300,
    csr_misa          = 12'h301,
    csr_mie           = 12'h304,
    csr_mtvec         = 12'h305,
    csr_mhpmevent3    = 12'h323, // First event selector
    csr_mscratch      = 12'h340,
    csr_mepc          = 12'h341,
    csr_mcause        = 12'h342,
    csr_mtval         = 12'h343,
    csr_mip           = 12'h344,
    csr_mcycle        = 12'hb00,
    csr_minstret      = 12'hb02,
    csr_mhpmcounter3  = 12'hb03, // Low half of the first counter
    csr_mcycleh       = 12'hb80,
    csr_minstreth     = 12'hb82,
    csr_mhpmcounter3h = 12'hb83
  } csr_addr_e;

  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_m = 2'b11
  } priv_e;

  typedef struct packed {
    logic [18:0] wpri_hi;
    priv_e       mpp;
    logic [2:0]  wpri_8;
    logic        mpie;
    logic [2:0]  wpri_4;
    logic        mie;
    logic [2:0]  wpri_0;
  } mstatus_t;

  typedef struct packed {
    logic [19:0] zero_hi;
    logic        meie;
    logic [2:0]  zero_8;
    logic        mtie;
    logic [2:0]  zero_4;
    logic        msie;
    logic [2:0]  zero_0;
  } mie_t;

  typedef struct packed {
    logic [19:0] zero_hi;
    logic        meip;
    logic [2:0]  zero_8;
    logic        mtip;
    logic [2:0]  zero_4;
    logic        msip;
    logic [2:0]  zero_0;
  } mip_t;

  typedef struct packed {
    mstatus_t    mstatus;
    mie_t        mie;
    mip_t        mip;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [63:0] mcycle;
    logic [63:0] minstret;
  } csr_machine_reg_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [11:0] addr;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic        sel_en;
    logic        lo_en;
    logic        hi_en;
    logic [31:0] data;
  } hpm_write_t;

endpackage

// File: design/trap_pkg.sv
package trap_pkg;

  typedef enum logic [3:0] {
    cause_insn_misaligned  = 4'd0,
    cause_insn_fault       = 4'd1,
    cause_illegal_insn     = 4'd2,
    cause_breakpoint       = 4'd3,
    cause_load_misaligned  = 4'd4,
    cause_load_fault       = 4'd5,
    cause_store_misaligned = 4'd6,
    cause_store_fault      = 4'd7,
    cause_ecall_u          = 4'd8,
    cause_ecall_m          = 4'd11
  } cause_e;

  // Interrupt codes share values with exception codes
  localparam cause_e cause_irq_m_soft  = cause_e'(4'd3);
  localparam cause_e cause_irq_m_timer = cause_e'(4'd7);
  localparam cause_e cause_irq_m_ext   = cause_e'(4'd11);

  typedef struct packed {
    logic        valid;
    logic        exception;
    cause_e      cause;
    logic [31:0] epc;
    logic [31:0] tval;
    logic        mret;
  } retire_t;

  typedef struct packed {
    logic        trap;
    logic        mret;
    logic        interrupt; // Cause of the trap is an interrupt
    logic [31:0] target;
    logic [31:0] mepc;
  } trap_out_t;

  typedef enum logic [2:0] {
    ev_none, ev_cycle, ev_instret, ev_exception, ev_interrupt, ev_mret, ev_csr_write
  } perf_event_e;

  localparam int perf_event_count = 7;

endpackage

// File: design/wb_csr_port.sv
module wb_csr_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              cyc,
  input  logic              stb,
  input  logic              we,
  input  logic [11:0]       adr,
  input  logic [31:0]       dat_w,
  output logic [31:0]       dat_r,
  output logic              ack,
  output csr_pkg::csr_req_t req,
  input  logic [31:0]       rdata
);

  typedef enum logic {
    st_idle,
    st_ack
  } state_e;

  state_e      state;
  logic        req_valid;
  logic        req_write;
  logic [11:0] req_addr;
  logic [31:0] req_wdata;
  logic        start;

  assign start = (state == st_idle) && cyc && stb;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state     <= st_idle;
      req_valid <= 1'b0;
      ack       <= 1'b0;
    end else begin
      req_valid <= start;
      case (state)
        st_idle: begin
          ack <= 1'b0;
          if (start) begin
            state <= st_ack;
          end
        end
        st_ack: begin
          if (!ack) begin
            ack <= 1'b1; // Request is being served this cycle
          end else begin
            ack   <= 1'b0;
            state <= st_idle; // Master moves on after seeing ack
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_write <= we;
      req_addr  <= adr;
      req_wdata <= dat_w;
    end
    if (req_valid) begin
      dat_r <= rdata;
    end
  end

  assign req = '{valid: req_valid, write: req_write, addr: req_addr, wdata: req_wdata};

endmodule

// File: design/csr_file.sv
`include "csr_settings.svh"

module csr_file (
  input  logic                  clk,
  input  logic                  rst,
  input  csr_pkg::csr_req_t     req,
  output logic [31:0]           rdata,
  input  trap_pkg::retire_t     retire,
  input  logic                  meip,
  input  logic                  mtip,
  input  logic                  msip,
  output trap_pkg::trap_out_t   trap,
  output csr_pkg::hpm_write_t   hpm_wr    [`HPM_COUNT],
  input  logic [63:0]           hpm_count [`HPM_COUNT],
  input  trap_pkg::perf_event_e hpm_event [`HPM_COUNT]
);

  localparam logic [11:0] cnt_lo_base = csr_pkg::csr_mhpmcounter3;
  localparam logic [11:0] cnt_hi_base = csr_pkg::csr_mhpmcounter3h;
  localparam logic [11:0] sel_base    = csr_pkg::csr_mhpmevent3;

  csr_pkg::csr_machine_reg_t regs;
  logic                      trap_q;
  logic                      mret_q;
  logic                      bus_wr;
  logic                      irq_ext;
  logic                      irq_tmr;
  logic                      irq_sw;
  logic                      take_exc;
  logic                      take_irq;
  logic                      take_mret;
  trap_pkg::cause_e          irq_cause;
  logic [31:0]               trap_base;
  logic [31:0]               target;

  assign bus_wr = req.valid && req.write;

  // Interrupt priority is external, timer, software
  assign irq_ext   = regs.mstatus.mie && regs.mie.meie && regs.mip.meip;
  assign irq_tmr   = regs.mstatus.mie && regs.mie.mtie && regs.mip.mtip;
  assign irq_sw    = regs.mstatus.mie && regs.mie.msie && regs.mip.msip;
  assign take_exc  = retire.exception;
  assign take_irq  = retire.valid && !retire.exception && (irq_ext || irq_tmr || irq_sw);
  assign take_mret = retire.mret && !take_exc && !take_irq;
  assign irq_cause = irq_ext ? trap_pkg::cause_irq_m_ext :
                     irq_tmr ? trap_pkg::cause_irq_m_timer : trap_pkg::cause_irq_m_soft;

  always_comb begin
    rdata = '0;
    case (req.addr)
      csr_pkg::csr_mstatus:   rdata = regs.mstatus;
      csr_pkg::csr_misa:      rdata = `MISA_VALUE;
      csr_pkg::csr_mie:       rdata = regs.mie;
      csr_pkg::csr_mip:       rdata = regs.mip;
      csr_pkg::csr_mtvec:     rdata = regs.mtvec;
      csr_pkg::csr_mscratch:  rdata = regs.mscratch;
      csr_pkg::csr_mepc:      rdata = regs.mepc;
      csr_pkg::csr_mcause:    rdata = regs.mcause;
      csr_pkg::csr_mtval:     rdata = regs.mtval;
      csr_pkg::csr_mcycle:    rdata = regs.mcycle[31:0];
      csr_pkg::csr_mcycleh:   rdata = regs.mcycle[63:32];
      csr_pkg::csr_minstret:  rdata = regs.minstret[31:0];
      csr_pkg::csr_minstreth: rdata = regs.minstret[63:32];
      default: begin
        for (int i = 0; i < `HPM_COUNT; i++) begin
          if (req.addr == cnt_lo_base + 12'(i)) rdata = hpm_count[i][31:0];
          if (req.addr == cnt_hi_base + 12'(i)) rdata = hpm_count[i][63:32];
          if (req.addr == sel_base + 12'(i))    rdata = 32'(hpm_event[i]);
        end
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i < `HPM_COUNT; i++) begin
      hpm_wr[i].sel_en = bus_wr && (req.addr == sel_base + 12'(i));
      hpm_wr[i].lo_en  = bus_wr && (req.addr == cnt_lo_base + 12'(i));
      hpm_wr[i].hi_en  = bus_wr && (req.addr == cnt_hi_base + 12'(i));
      hpm_wr[i].data   = req.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      regs             <= '0;
      regs.mstatus.mpp <= csr_pkg::priv_m;
      regs.mtvec       <= `MTVEC_RESET;
      trap_q           <= 1'b0;
      mret_q           <= 1'b0;
    end else begin
      regs.mcycle   <= regs.mcycle + 64'd1;
      if (retire.valid) begin
        regs.minstret <= regs.minstret + 64'd1;
      end
      regs.mip.meip <= meip;
      regs.mip.mtip <= mtip;
      regs.mip.msip <= msip;

      if (bus_wr) begin
        case (req.addr)
          csr_pkg::csr_mstatus: begin
            if (req.wdata[12:11] == csr_pkg::priv_m || req.wdata[12:11] == csr_pkg::priv_u) begin
              regs.mstatus.mpp <= csr_pkg::priv_e'(req.wdata[12:11]);
            end
            regs.mstatus.mpie <= req.wdata[7];
            regs.mstatus.mie  <= req.wdata[3];
          end
          csr_pkg::csr_mie: begin
            regs.mie.meie <= req.wdata[11];
            regs.mie.mtie <= req.wdata[7];
            regs.mie.msie <= req.wdata[3];
          end
          csr_pkg::csr_mtvec:     regs.mtvec <= req.wdata;
          csr_pkg::csr_mscratch:  regs.mscratch <= req.wdata;
          csr_pkg::csr_mepc:      regs.mepc <= req.wdata;
          csr_pkg::csr_mcause:    regs.mcause <= req.wdata;
          csr_pkg::csr_mtval:     regs.mtval <= req.wdata;
          csr_pkg::csr_mcycle:    regs.mcycle[31:0] <= req.wdata;
          csr_pkg::csr_mcycleh:   regs.mcycle[63:32] <= req.wdata;
          csr_pkg::csr_minstret:  regs.minstret[31:0] <= req.wdata;
          csr_pkg::csr_minstreth: regs.minstret[63:32] <= req.wdata;
          default: ;
        endcase
      end

      trap_q <= take_exc || take_irq;
      mret_q <= take_mret;
      if (take_exc || take_irq) begin // Overrides a bus write on the same edge
        regs.mstatus.mpie <= regs.mstatus.mie;
        regs.mstatus.mie  <= 1'b0;
        regs.mepc         <= retire.epc;
        if (take_exc) begin
          regs.mcause <= {28'd0, retire.cause};
          regs.mtval  <= retire.tval;
        end else begin
          regs.mcause <= {1'b1, 27'd0, irq_cause};
          regs.mtval  <= '0;
        end
      end else if (take_mret) begin
        regs.mstatus.mie  <= regs.mstatus.mpie;
        regs.mstatus.mpie <= 1'b1;
      end
    end
  end

  always_comb begin
    trap_base = {regs.mtvec[31:2], 2'b00};
    if (mret_q) begin
      target = regs.mepc;
    end else if (regs.mtvec[1:0] == 2'b01 && regs.mcause[31]) begin
      target = trap_base + {26'd0, regs.mcause[3:0], 2'b00}; // Vectored
    end else begin
      target = trap_base;
    end
  end

  assign trap = '{trap: trap_q, mret: mret_q, interrupt: regs.mcause[31],
                  target: target, mepc: regs.mepc};

endmodule

// File: design/perf_event_gen.sv
module perf_event_gen (
  input  logic                                   clk,
  input  logic                                   rst,
  input  trap_pkg::retire_t                      retire,
  input  trap_pkg::trap_out_t                    trap,
  input  logic                                   csr_write,
  output logic [trap_pkg::perf_event_count-1:0] events
);

  logic [trap_pkg::perf_event_count-1:0] events_d;

  always_comb begin
    events_d                          = '0; // ev_none never fires
    events_d[trap_pkg::ev_cycle]      = 1'b1;
    events_d[trap_pkg::ev_instret]    = retire.valid;
    events_d[trap_pkg::ev_exception]  = trap.trap && !trap.interrupt;
    events_d[trap_pkg::ev_interrupt]  = trap.trap && trap.interrupt;
    events_d[trap_pkg::ev_mret]       = trap.mret;
    events_d[trap_pkg::ev_csr_write]  = csr_write;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      events <= '0;
    end else begin
      events <= events_d;
    end
  end

endmodule

// File: design/hpm_counter.sv
module hpm_counter (
  input  logic                                   clk,
  input  logic                                   rst,
  input  csr_pkg::hpm_write_t                    wr,
  input  logic [trap_pkg::perf_event_count-1:0] events,
  output logic [63:0]                            count,
  output trap_pkg::perf_event_e                  event_sel
);

  logic hit;

  assign hit = events[event_sel];

  always_ff @(posedge clk) begin
    if (!rst) begin
      count     <= '0;
      event_sel <= trap_pkg::ev_none;
    end else begin
      if (wr.sel_en) begin
        event_sel <= trap_pkg::perf_event_e'(wr.data[2:0]);
      end
      if (hit && !wr.lo_en && !wr.hi_en) begin
        count <= count + 64'd1;
      end
      if (wr.lo_en) begin
        count[31:0] <= wr.data;
      end
      if (wr.hi_en) begin
        count[63:32] <= wr.data;
      end
    end
  end

endmodule

// File: design/csr_subsystem.sv
`include "csr_settings.svh"

module csr_subsystem (
  input  logic                clk,
  input  logic                rst,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  logic [11:0]         adr,
  input  logic [31:0]         dat_w,
  output logic [31:0]         dat_r,
  output logic                ack,
  input  trap_pkg::retire_t   retire,
  input  logic                meip,
  input  logic                mtip,
  input  logic                msip,
  output trap_pkg::trap_out_t trap
);

  csr_pkg::csr_req_t                     req;
  logic [31:0]                           rdata;
  logic                                  csr_write;
  logic [trap_pkg::perf_event_count-1:0] events;
  csr_pkg::hpm_write_t                   hpm_wr    [`HPM_COUNT];
  logic [63:0]                           hpm_count [`HPM_COUNT];
  trap_pkg::perf_event_e                 hpm_event [`HPM_COUNT];

  assign csr_write = req.valid && req.write;

  wb_csr_port u_port (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .req   (req),
    .rdata (rdata)
  );

  csr_file u_csr_file (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .rdata     (rdata),
    .retire    (retire),
    .meip      (meip),
    .mtip      (mtip),
    .msip      (msip),
    .trap      (trap),
    .hpm_wr    (hpm_wr),
    .hpm_count (hpm_count),
    .hpm_event (hpm_event)
  );

  perf_event_gen u_event_gen (
    .clk       (clk),
    .rst       (rst),
    .retire    (retire),
    .trap      (trap),
    .csr_write (csr_write),
    .events    (events)
  );

  for (genvar i = 0; i < `HPM_COUNT; i++) begin : g_hpm
    hpm_counter u_hpm (
      .clk       (clk),
      .rst       (rst),
      .wr        (hpm_wr[i]),
      .events    (events),
      .count     (hpm_count[i]),
      .event_sel (hpm_event[i])
    );
  end

endmodule

// File: verif/tb_clock.sv
module tb_clock #(
  parameter int period = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule

// File: verif/csr_tb.sv
module csr_tb;

  localparam int rec_words   = 7; // test, op, then five fields
  localparam int max_records = 128;

  localparam logic [31:0] op_wb_write   = 32'd1;
  localparam logic [31:0] op_wb_read    = 32'd2;
  localparam logic [31:0] op_retire     = 32'd3;
  localparam logic [31:0] op_exception  = 32'd4;
  localparam logic [31:0] op_mret       = 32'd5;
  localparam logic [31:0] op_irq        = 32'd6;
  localparam logic [31:0] op_idle       = 32'd7;
  localparam logic [31:0] op_rand_write = 32'd8;
  localparam logic [31:0] op_rand_read  = 32'd9;

  logic                clk;
  logic                rst;
  logic                cyc;
  logic                stb;
  logic                we;
  logic [11:0]         adr;
  logic [31:0]         dat_w;
  logic [31:0]         dat_r;
  logic                ack;
  trap_pkg::retire_t   retire;
  logic                meip;
  logic                mtip;
  logic                msip;
  trap_pkg::trap_out_t trap;

  logic [31:0] trace_mem [max_records * rec_words];
  int          record_count;
  int          cycle_limit;
  int          cycles;
  logic [31:0] rand_state;
  logic [31:0] rand_data;
  logic [31:0] cur_test;
  int          test_checks;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  int          total_errors;

  tb_clock #(.period(4)) u_clock (
    .clk (clk)
  );

  csr_subsystem u_dut (
    .clk    (clk),
    .rst    (rst),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .dat_w  (dat_w),
    .dat_r  (dat_r),
    .ack    (ack),
    .retire (retire),
    .meip   (meip),
    .mtip   (mtip),
    .msip   (msip),
    .trap   (trap)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    test_checks++;
    assert (actual === expected) else begin
      $display("error: %s expected %08h actual %08h", name, expected, actual);
      test_errors++;
    end
  endtask

  // One Wishbone classic cycle held until ack
  task automatic wb_access(input logic write, input logic [11:0] addr,
                           input logic [31:0] data, output logic [31:0] rd);
    int   waited;
    logic got_ack;
    waited  = 0;
    got_ack = 1'b0;
    cyc     = 1'b1;
    stb     = 1'b1;
    we      = write;
    adr     = addr;
    dat_w   = data;
    while (!got_ack && waited < 8) begin
      @(posedge clk);
      #1;
      waited++;
      got_ack = ack;
    end
    rd  = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    test_checks++;
    assert (got_ack) else begin
      $display("no ack from the CSR port within 8 cycles for address %03h", addr);
      test_errors++;
    end
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] expected);
    logic [31:0] rd;
    wb_access(1'b0, addr, 32'd0, rd);
    check_value($sformatf("dat_r[%03h]", addr), expected, rd);
  endtask

  // Kind 0 expects no trap, 1 a trap entry, 2 an mret
  task automatic drive_retire(input logic [31:0] op, input logic [31:0] epc,
                              input logic [31:0] cause, input logic [31:0] tval,
                              input logic [31:0] exp_kind, input logic [31:0] exp_target);
    retire.valid     = (op != op_exception);
    retire.exception = (op == op_exception);
    retire.mret      = (op == op_mret);
    retire.cause     = trap_pkg::cause_e'(cause[3:0]);
    retire.epc       = epc;
    retire.tval      = tval;
    @(posedge clk);
    #1;
    check_value("trap.trap", {31'd0, exp_kind == 32'd1}, {31'd0, trap.trap});
    check_value("trap.mret", {31'd0, exp_kind == 32'd2}, {31'd0, trap.mret});
    if (exp_kind == 32'd1) begin
      check_value("trap.target", exp_target, trap.target);
      check_value("trap.mepc", epc, trap.mepc);
      // A plain retire only traps on a pending interrupt
      check_value("trap.interrupt", {31'd0, op == op_retire}, {31'd0, trap.interrupt});
    end else if (exp_kind == 32'd2) begin
      check_value("trap.target", exp_target, trap.target);
      check_value("trap.mepc", exp_target, trap.mepc);
    end
    retire = '0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("test %0d passed, %0d checks", cur_test, test_checks);
      tests_passed++;
    end else begin
      $display("test %0d failed, %0d of %0d checks wrong", cur_test, test_errors, test_checks);
      tests_failed++;
    end
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    int          base;
    logic [31:0] op;
    logic [31:0] rd;
    rst          = 1'b0;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    dat_w        = '0;
    retire       = '0;
    meip         = 1'b0;
    mtip         = 1'b0;
    msip         = 1'b0;
    cycles       = 0;
    cycle_limit  = 0;
    rand_state   = 32'he99c_4445;
    rand_data    = '0;
    cur_test     = '0;
    test_checks  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    total_errors = 0;

    for (int i = 0; i < max_records * rec_words; i++) begin
      trace_mem[i] = '0;
    end
    $readmemh("verif/csr_trace.txt", trace_mem);
    record_count = 0;
    while (record_count < max_records && trace_mem[record_count * rec_words + 1] != 32'd0) begin
      record_count++;
    end
    cycle_limit = 20 * record_count + 100;
    if (record_count == 0) begin
      $display("trace file holds no operations");
      total_errors++;
    end

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;

    for (int r = 0; r < record_count; r++) begin
      base = r * rec_words;
      op   = trace_mem[base + 1];
      if (trace_mem[base] != cur_test) begin
        if (cur_test != 32'd0) begin
          finish_test();
        end
        cur_test = trace_mem[base];
      end
      case (op)
        op_wb_write: wb_access(1'b1, trace_mem[base + 2][11:0], trace_mem[base + 3], rd);
        op_wb_read:  read_check(trace_mem[base + 2][11:0], trace_mem[base + 3]);
        op_retire, op_exception, op_mret: begin
          drive_retire(op, trace_mem[base + 2], trace_mem[base + 3], trace_mem[base + 4],
                       trace_mem[base + 5], trace_mem[base + 6]);
        end
        op_irq: begin
          meip = trace_mem[base + 2][0];
          mtip = trace_mem[base + 3][0];
          msip = trace_mem[base + 4][0];
          @(posedge clk);
          #1;
        end
        op_idle: begin
          for (int i = 0; i < trace_mem[base + 2]; i++) begin
            @(posedge clk);
            #1;
          end
        end
        op_rand_write: begin
          rand_state = next_random(rand_state);
          rand_data  = rand_state;
          wb_access(1'b1, trace_mem[base + 2][11:0], rand_data, rd);
        end
        op_rand_read: read_check(trace_mem[base + 2][11:0], rand_data);
        default: begin
          $display("unknown operation %0h in trace record %0d", op, r);
          test_errors++;
        end
      endcase
    end
    if (cur_test != 32'd0) begin
      finish_test();
    end

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verif/csr_trace.txt
// test op a b c d e (hex). op 1 write addr,data  2 read addr,expected  6 irq meip,mtip,msip
// op 3 retire, 4 exception, 5 mret: epc,cause,tval,kind(0 none 1 trap 2 mret),target
// op 7 idle cycles  8 random write addr  9 random read addr
1 8 340 00000000 0 0 00000000
1 9 340 00000000 0 0 00000000
1 1 305 00000200 0 0 00000000
1 2 305 00000200 0 0 00000000
1 1 341 80001234 0 0 00000000
1 2 341 80001234 0 0 00000000
1 1 300 ffffefff 0 0 00000000
1 2 300 00001888 0 0 00000000
1 2 301 40001100 0 0 00000000
1 2 7c0 00000000 0 0 00000000
2 1 300 00001808 0 0 00000000
2 2 300 00001808 0 0 00000000
2 4 00000400 2 deadbeef 1 00000200
2 2 341 00000400 0 0 00000000
2 2 342 00000002 0 0 00000000
2 2 343 deadbeef 0 0 00000000
2 2 300 00001880 0 0 00000000
2 5 00000000 0 00000000 2 00000400
2 2 300 00001888 0 0 00000000
3 1 305 00000301 0 0 00000000
3 1 304 00000880 0 0 00000000
3 2 304 00000880 0 0 00000000
3 6 1 1 0 0 00000000
3 7 2 0 0 0 00000000
3 3 00000500 0 00000000 1 0000032c
3 2 342 8000000b 0 0 00000000
3 2 341 00000500 0 0 00000000
3 2 343 00000000 0 0 00000000
3 2 300 00001880 0 0 00000000
3 3 00000600 0 00000000 0 00000000
3 6 0 0 0 0 00000000
3 7 2 0 0 0 00000000
4 1 b02 fffffffe 0 0 00000000
4 1 b82 00000012 0 0 00000000
4 3 00001000 0 00000000 0 00000000
4 3 00001004 0 00000000 0 00000000
4 3 00001008 0 00000000 0 00000000
4 2 b02 00000001 0 0 00000000
4 2 b82 00000013 0 0 00000000
5 1 323 00000002 0 0 00000000
5 1 324 00000006 0 0 00000000
5 1 325 00000005 0 0 00000000
5 1 b03 00000000 0 0 00000000
5 1 b04 00000000 0 0 00000000
5 1 b05 00000000 0 0 00000000
5 3 00002000 0 00000000 0 00000000
5 3 00002004 0 00000000 0 00000000
5 4 00000700 b 00000000 1 00000300
5 5 00000000 0 00000000 2 00000700
5 1 340 12345678 0 0 00000000
5 3 00002008 0 00000000 0 00000000
5 5 00000000 0 00000000 2 00000700
5 2 b03 00000005 0 0 00000000
5 2 b04 00000003 0 0 00000000
5 2 b05 00000002 0 0 00000000
5 2 b83 00000000 0 0 00000000
5 2 324 00000006 0 0 00000000

// File: build.f
+incdir+design
design/csr_pkg.sv
design/trap_pkg.sv
design/wb_csr_port.sv
design/csr_file.sv
design/perf_event_gen.sv
design/hpm_counter.sv
design/csr_subsystem.sv
verif/tb_clock.sv
verif/csr_tb.sv

// File: Makefile
all: run

obj_dir/Vcsr_tb: build.f design/*.sv design/*.svh verif/*.sv
	verilator --binary --timing --assert -f build.f --top-module csr_tb -o Vcsr_tb

run: obj_dir/Vcsr_tb
	@out="$$(./obj_dir/Vcsr_tb)"; echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only --timing --assert -f build.f --top-module csr_tb

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
